/* hw/lcd_pkg.sv */
package lcd_pkg;

	// timing, all in microseconds and scaled by US_CYCLES
	localparam int US_CYCLES = 2; // kept small for simulation
	localparam int POWERUP_US = 500;
	localparam int SETUP_US = 1;
	localparam int E_HIGH_US = 13;
	localparam int SHORT_US = 50;
	localparam int LONG_US = 200; // clear and home

	localparam int POWERUP_CYCLES = POWERUP_US * US_CYCLES;
	localparam int SETUP_CYCLES = SETUP_US * US_CYCLES;
	localparam int E_HIGH_CYCLES = E_HIGH_US * US_CYCLES;
	localparam int SHORT_CYCLES = SHORT_US * US_CYCLES;
	localparam int LONG_CYCLES = LONG_US * US_CYCLES;
	localparam int PWR_CNT_W = $clog2(POWERUP_CYCLES);
	localparam int SLOT_CNT_W = $clog2(LONG_CYCLES);

	localparam int FIFO_DEPTH = 8;
	localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
	localparam int FIFO_CNT_W = 4; // holds 0 to FIFO_DEPTH

	localparam logic [3:0] REG_CTRL = 4'h0;
	localparam logic [3:0] REG_DATA = 4'h4;
	localparam logic [3:0] REG_STATUS = 4'h8;

	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	typedef struct packed {
		logic lines; // function set
		logic font;
		logic disp_on; // on/off control
		logic cursor_on;
		logic blink;
		logic increment; // entry mode
		logic shift;
	} lcd_cfg_t;

	typedef struct packed {
		logic rs; // 1 for data, 0 for command
		logic [7:0] data;
	} lcd_cmd_t;

	typedef struct packed {
		logic e;
		logic rs;
		logic rw;
		logic [7:0] data;
	} lcd_pins_t;

	typedef struct packed {
		logic awvalid;
		logic [3:0] awaddr;
		logic wvalid;
		logic [31:0] wdata;
		logic bready;
		logic arvalid;
		logic [3:0] araddr;
		logic rready;
	} axil_req_t;

	typedef struct packed {
		logic awready;
		logic wready;
		logic bvalid;
		logic [1:0] bresp;
		logic arready;
		logic rvalid;
		logic [31:0] rdata;
		logic [1:0] rresp;
	} axil_rsp_t;

endpackage

/* hw/lcd_axil_regs.sv */
`timescale 1ns/1ps

module lcd_axil_regs (
	input  logic clk,
	input  logic rst,
	input  lcd_pkg::axil_req_t axil,
	input  logic fifo_full,
	input  logic [lcd_pkg::FIFO_CNT_W-1:0] fifo_count,
	input  logic init_done,
	input  logic bus_active,
	output lcd_pkg::axil_rsp_t axil_rsp,
	output lcd_pkg::lcd_cfg_t cfg,
	output logic start,
	output logic push_valid,
	output lcd_pkg::lcd_cmd_t push_cmd
);

	logic wr_go;
	logic rd_go;
	logic bvalid_q;
	logic rvalid_q;
	logic [1:0] bresp_q;
	logic [1:0] rresp_q;
	logic [31:0] rdata_q;
	logic busy;
	logic [31:0] status_word;

	// address and data must arrive together, one response outstanding
	assign wr_go = axil.awvalid && axil.wvalid && !bvalid_q;
	assign rd_go = axil.arvalid && !rvalid_q;

	// data writes go straight into the queue unless it is full
	assign push_valid = wr_go && axil.awaddr == lcd_pkg::REG_DATA && !fifo_full;
	assign push_cmd = lcd_pkg::lcd_cmd_t'(axil.wdata[8:0]);

	assign busy = bus_active || fifo_count != '0;
	assign status_word = {24'd0, fifo_count, 2'b00, busy, init_done};

	always_comb begin
		axil_rsp.awready = wr_go;
		axil_rsp.wready = wr_go;
		axil_rsp.bvalid = bvalid_q;
		axil_rsp.bresp = bresp_q;
		axil_rsp.arready = rd_go;
		axil_rsp.rvalid = rvalid_q;
		axil_rsp.rdata = rdata_q;
		axil_rsp.rresp = rresp_q;
	end

	// write channel control and config register
	always_ff @(posedge clk) begin
		if (rst) begin
			bvalid_q <= 1'b0;
			cfg <= '0;
			start <= 1'b0;
		end else begin
			start <= 1'b0; // single cycle pulse
			if (wr_go) begin
				bvalid_q <= 1'b1;
				if (axil.awaddr == lcd_pkg::REG_CTRL) begin
					cfg <= lcd_pkg::lcd_cfg_t'(axil.wdata[6:0]);
					start <= axil.wdata[8];
				end
			end else if (bvalid_q && axil.bready) begin
				bvalid_q <= 1'b0;
			end
		end
	end

	// write response code
	always_ff @(posedge clk) begin
		if (wr_go) begin
			case (axil.awaddr)
				lcd_pkg::REG_CTRL: bresp_q <= lcd_pkg::RESP_OKAY;
				lcd_pkg::REG_DATA: begin
					bresp_q <= fifo_full ? lcd_pkg::RESP_SLVERR : lcd_pkg::RESP_OKAY;
				end
				default: bresp_q <= lcd_pkg::RESP_SLVERR; // status is read only
			endcase
		end
	end

	// read channel handshake
	always_ff @(posedge clk) begin
		if (rst) begin
			rvalid_q <= 1'b0;
		end else if (rd_go) begin
			rvalid_q <= 1'b1;
		end else if (rvalid_q && axil.rready) begin
			rvalid_q <= 1'b0;
		end
	end

	// read data held until rready
	always_ff @(posedge clk) begin
		if (rd_go) begin
			case (axil.araddr)
				lcd_pkg::REG_CTRL: begin
					rdata_q <= {25'd0, cfg};
					rresp_q <= lcd_pkg::RESP_OKAY;
				end
				lcd_pkg::REG_STATUS: begin
					rdata_q <= status_word;
					rresp_q <= lcd_pkg::RESP_OKAY;
				end
				default: begin
					rdata_q <= '0; // data reg is write only
					rresp_q <= lcd_pkg::RESP_SLVERR;
				end
			endcase
		end
	end

endmodule

/* hw/lcd_cmd_fifo.sv */
`timescale 1ns/1ps

module lcd_cmd_fifo (
	input  logic clk,
	input  logic rst,
	input  logic push_valid,
	input  lcd_pkg::lcd_cmd_t push_cmd,
	input  logic pop_ready,
	output logic full,
	output logic [lcd_pkg::FIFO_CNT_W-1:0] count,
	output logic pop_valid,
	output lcd_pkg::lcd_cmd_t pop_cmd
);

	lcd_pkg::lcd_cmd_t mem [lcd_pkg::FIFO_DEPTH];
	logic [lcd_pkg::FIFO_PTR_W-1:0] wr_ptr;
	logic [lcd_pkg::FIFO_PTR_W-1:0] rd_ptr;
	logic do_push;
	logic do_pop;

	assign full = count == lcd_pkg::FIFO_CNT_W'(lcd_pkg::FIFO_DEPTH);
	assign pop_valid = count != '0;
	assign pop_cmd = mem[rd_ptr]; // head of queue

	assign do_push = push_valid && !full; // push into a full queue is lost
	assign do_pop = pop_valid && pop_ready;

	// storage
	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= push_cmd;
		end
	end

	// pointers wrap naturally, depth is a power of two
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			count <= '0;
		end else begin
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count; // both or neither
			endcase
		end
	end

endmodule

/* hw/lcd_init_seq.sv */
`timescale 1ns/1ps

module lcd_init_seq (
	input  logic clk,
	input  logic rst,
	input  lcd_pkg::lcd_cfg_t cfg,
	input  logic start,
	input  logic in_valid,
	input  lcd_pkg::lcd_cmd_t in_cmd,
	input  logic out_ready,
	output logic in_ready,
	output logic out_valid,
	output lcd_pkg::lcd_cmd_t out_cmd,
	output logic init_done
);

	typedef enum logic [1:0] {
		ST_POWERUP,
		ST_WAIT_START,
		ST_ISSUE,
		ST_DONE
	} state_t;

	state_t state;
	logic [lcd_pkg::PWR_CNT_W-1:0] pwr_cnt;
	logic start_seen;
	logic [1:0] step;
	lcd_pkg::lcd_cfg_t cfg_q;
	logic [7:0] init_byte;

	// init commands built from the config captured at start
	always_comb begin
		case (step)
			2'd0: init_byte = {4'b0011, cfg_q.lines, cfg_q.font, 2'b00};
			2'd1: init_byte = {5'b00001, cfg_q.disp_on, cfg_q.cursor_on, cfg_q.blink};
			2'd2: init_byte = 8'h01; // clear
			default: init_byte = {6'b000001, cfg_q.increment, cfg_q.shift};
		endcase
	end

	assign init_done = state == ST_DONE;

	// host queue passes straight through once init is over
	always_comb begin
		if (state == ST_DONE) begin
			out_valid = in_valid;
			out_cmd = in_cmd;
			in_ready = out_ready;
		end else begin
			out_valid = state == ST_ISSUE;
			out_cmd = '{rs: 1'b0, data: init_byte};
			in_ready = 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_POWERUP;
			pwr_cnt <= '0;
			start_seen <= 1'b0;
			step <= '0;
		end else begin
			if (start) begin
				start_seen <= 1'b1; // may arrive during power-up
			end
			case (state)
				ST_POWERUP: begin
					pwr_cnt <= pwr_cnt + 1'b1;
					if (pwr_cnt == lcd_pkg::PWR_CNT_W'(lcd_pkg::POWERUP_CYCLES - 1)) begin
						state <= ST_WAIT_START;
					end
				end
				ST_WAIT_START: begin
					if (start_seen) begin
						state <= ST_ISSUE;
						step <= '0;
					end
				end
				ST_ISSUE: begin
					if (out_ready) begin
						step <= step + 1'b1;
						if (step == 2'd3) begin
							state <= ST_DONE; // entry mode was the last one
						end
					end
				end
				default: state <= ST_DONE;
			endcase
		end
	end

	// config snapshot so the commands hold steady while valid
	always_ff @(posedge clk) begin
		if (state == ST_WAIT_START) begin
			cfg_q <= cfg;
		end
	end

endmodule

/* hw/lcd_bus_timing.sv */
`timescale 1ns/1ps

module lcd_bus_timing (
	input  logic clk,
	input  logic rst,
	input  logic in_valid,
	input  lcd_pkg::lcd_cmd_t in_cmd,
	output logic in_ready,
	output lcd_pkg::lcd_pins_t lcd,
	output logic active
);

	logic busy_q;
	logic busy_nxt;
	logic [lcd_pkg::SLOT_CNT_W-1:0] cnt_q;
	logic [lcd_pkg::SLOT_CNT_W-1:0] cnt_nxt;
	logic [lcd_pkg::SLOT_CNT_W-1:0] slot_last;
	logic long_q;
	logic accept;
	logic e_q;
	logic rs_q;
	logic [7:0] data_q;

	assign in_ready = !busy_q;
	assign active = busy_q;
	assign accept = in_valid && in_ready;

	// ready comes back in the last pin cycle of the slot
	assign slot_last = long_q ? lcd_pkg::SLOT_CNT_W'(lcd_pkg::LONG_CYCLES - 2)
		: lcd_pkg::SLOT_CNT_W'(lcd_pkg::SHORT_CYCLES - 2);

	always_comb begin
		busy_nxt = busy_q;
		cnt_nxt = cnt_q;
		if (accept) begin
			busy_nxt = 1'b1;
			cnt_nxt = '0; // first setup cycle
		end else if (busy_q) begin
			cnt_nxt = cnt_q + 1'b1;
			if (cnt_q == slot_last) begin
				busy_nxt = 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			busy_q <= 1'b0;
			cnt_q <= '0;
			e_q <= 1'b0;
			rs_q <= 1'b0;
			data_q <= '0;
		end else begin
			busy_q <= busy_nxt;
			cnt_q <= cnt_nxt;
			// enable window after setup
			e_q <= busy_nxt && cnt_nxt >= lcd_pkg::SLOT_CNT_W'(lcd_pkg::SETUP_CYCLES)
				&& cnt_nxt < lcd_pkg::SLOT_CNT_W'(lcd_pkg::SETUP_CYCLES
				+ lcd_pkg::E_HIGH_CYCLES);
			if (accept) begin
				rs_q <= in_cmd.rs;
				data_q <= in_cmd.data;
			end
		end
	end

	// clear and home are the slow instructions
	always_ff @(posedge clk) begin
		if (accept) begin
			long_q <= !in_cmd.rs && in_cmd.data[7:2] == 6'd0;
		end
	end

	always_comb begin
		lcd.e = e_q;
		lcd.rs = rs_q;
		lcd.rw = 1'b0; // write only
		lcd.data = data_q;
	end

endmodule

/* hw/lcd_top.sv */
`timescale 1ns/1ps

module lcd_top (
	input  logic clk,
	input  logic rst,
	input  lcd_pkg::axil_req_t axil,
	output lcd_pkg::axil_rsp_t axil_rsp,
	output lcd_pkg::lcd_pins_t lcd
);

	lcd_pkg::lcd_cfg_t cfg;
	logic start;
	logic push_valid;
	lcd_pkg::lcd_cmd_t push_cmd;
	logic fifo_full;
	logic [lcd_pkg::FIFO_CNT_W-1:0] fifo_count;
	logic q_valid; // queue to sequencer
	logic q_ready;
	lcd_pkg::lcd_cmd_t q_cmd;
	logic s_valid; // sequencer to bus timing
	logic s_ready;
	lcd_pkg::lcd_cmd_t s_cmd;
	logic init_done;
	logic bus_active;

	lcd_axil_regs regs_i (
		.clk(clk),
		.rst(rst),
		.axil(axil),
		.fifo_full(fifo_full),
		.fifo_count(fifo_count),
		.init_done(init_done),
		.bus_active(bus_active),
		.axil_rsp(axil_rsp),
		.cfg(cfg),
		.start(start),
		.push_valid(push_valid),
		.push_cmd(push_cmd)
	);

	lcd_cmd_fifo fifo_i (
		.clk(clk),
		.rst(rst),
		.push_valid(push_valid),
		.push_cmd(push_cmd),
		.pop_ready(q_ready),
		.full(fifo_full),
		.count(fifo_count),
		.pop_valid(q_valid),
		.pop_cmd(q_cmd)
	);

	lcd_init_seq seq_i (
		.clk(clk),
		.rst(rst),
		.cfg(cfg),
		.start(start),
		.in_valid(q_valid),
		.in_cmd(q_cmd),
		.out_ready(s_ready),
		.in_ready(q_ready),
		.out_valid(s_valid),
		.out_cmd(s_cmd),
		.init_done(init_done)
	);

	lcd_bus_timing bus_i (
		.clk(clk),
		.rst(rst),
		.in_valid(s_valid),
		.in_cmd(s_cmd),
		.in_ready(s_ready),
		.lcd(lcd),
		.active(bus_active)
	);

endmodule

/* bench/lcd_tb.sv */
`timescale 1ns/1ps

module lcd_tb;

	localparam int HS_TIMEOUT = 50; // cycles per handshake wait
	localparam int XFER_TIMEOUT = 3000; // covers the power-up wait
	localparam int IDLE_TIMEOUT = 300; // status polls

	typedef struct packed {
		lcd_pkg::lcd_cmd_t cmd;
		logic rw;
		int chg; // -1 when the pins did not change
		int rise;
		int fall;
	} xfer_t;

	logic clk = 1'b0;
	logic rst = 1'b1;
	lcd_pkg::axil_req_t req;
	lcd_pkg::axil_rsp_t rsp;
	lcd_pkg::lcd_pins_t lcd;

	lcd_pkg::lcd_pins_t prev_pins = '0;
	int cyc = 0;
	int chg_cyc = -1;
	int rise_cyc = 0;
	int first_rise = -1;
	int seen_total = 0;
	int rise_total = 0;
	logic rw_hit = 1'b0;
	xfer_t seen[$];
	lcd_pkg::lcd_cmd_t model[$];
	int errors = 0;
	int tests_pass = 0;
	int tests_fail = 0;

	lcd_top dut_i (
		.clk(clk),
		.rst(rst),
		.axil(req),
		.axil_rsp(rsp),
		.lcd(lcd)
	);

	always #2 clk = ~clk;

	// pin monitor, sampled mid cycle
	always @(negedge clk) begin
		if (rst) begin
			cyc = 0;
			chg_cyc = -1;
			prev_pins = lcd;
		end else begin
			cyc = cyc + 1;
			if (lcd.rw) begin
				rw_hit = 1'b1;
			end
			if (lcd.rs != prev_pins.rs || lcd.data != prev_pins.data) begin
				chg_cyc = cyc;
			end
			if (lcd.e && !prev_pins.e) begin
				rise_cyc = cyc;
				rise_total++;
				if (first_rise < 0) begin
					first_rise = cyc;
				end
			end
			if (!lcd.e && prev_pins.e) begin // write strobe ends here
				seen.push_back('{cmd: '{rs: lcd.rs, data: lcd.data}, rw: rw_hit,
					chg: chg_cyc, rise: rise_cyc, fall: cyc});
				seen_total++;
				chg_cyc = -1;
				rw_hit = 1'b0;
			end
			prev_pins = lcd;
		end
	end

	task automatic report_timeout(input string what);
		$display("Timed out at %0t ns waiting for %s", $time, what);
		errors++;
	endtask

	task automatic compare_cmd(input string name, input lcd_pkg::lcd_cmd_t exp,
		input lcd_pkg::lcd_cmd_t act);
		if (act !== exp) begin
			$display("Fail at %0t ns: %s expected rs=%0b data=%02h, got rs=%0b data=%02h",
				$time, name, exp.rs, exp.data, act.rs, act.data);
			errors++;
		end
	endtask

	task automatic compare_resp(input string name, input logic [1:0] exp,
		input logic [1:0] act);
		if (act !== exp) begin
			$display("Fail at %0t ns: %s expected %02b, got %02b", $time, name, exp, act);
			errors++;
		end
	endtask

	task automatic compare_word(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		if (act !== exp) begin
			$display("Fail at %0t ns: %s expected %08h, got %08h", $time, name, exp, act);
			errors++;
		end
	endtask

	task automatic compare_cycles(input string name, input int exp, input int act);
		if (act != exp) begin
			$display("Fail at %0t ns: %s expected %0d cycles, got %0d", $time, name, exp, act);
			errors++;
		end
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#0.5;
	endtask

	task automatic axil_write(input logic [3:0] addr, input logic [31:0] data,
		output logic [1:0] resp);
		int n;
		req.awvalid = 1'b1;
		req.awaddr = addr;
		req.wvalid = 1'b1;
		req.wdata = data;
		req.bready = 1'b1;
		n = 0;
		@(negedge clk);
		while (!(rsp.awready && rsp.wready) && n < HS_TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (!(rsp.awready && rsp.wready)) begin
			report_timeout("awready and wready");
		end
		next_cycle();
		req.awvalid = 1'b0;
		req.wvalid = 1'b0;
		resp = 2'bxx;
		n = 0;
		@(negedge clk);
		while (!rsp.bvalid && n < HS_TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (rsp.bvalid) begin
			resp = rsp.bresp;
		end else begin
			report_timeout("bvalid");
		end
		next_cycle(); // bready is high, response retires here
	endtask

	task automatic axil_read(input logic [3:0] addr, output logic [31:0] data,
		output logic [1:0] resp);
		int n;
		req.arvalid = 1'b1;
		req.araddr = addr;
		req.rready = 1'b1;
		n = 0;
		@(negedge clk);
		while (!rsp.arready && n < HS_TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (!rsp.arready) begin
			report_timeout("arready");
		end
		next_cycle();
		req.arvalid = 1'b0;
		data = 'x;
		resp = 2'bxx;
		n = 0;
		@(negedge clk);
		while (!rsp.rvalid && n < HS_TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (rsp.rvalid) begin
			data = rsp.rdata;
			resp = rsp.rresp;
		end else begin
			report_timeout("rvalid");
		end
		next_cycle();
	endtask

	task automatic wait_idle(output logic [31:0] status);
		logic [1:0] resp;
		int n;
		n = 0;
		axil_read(lcd_pkg::REG_STATUS, status, resp);
		while (status[1] && n < IDLE_TIMEOUT) begin
			axil_read(lcd_pkg::REG_STATUS, status, resp);
			n++;
		end
		if (status[1]) begin
			report_timeout("the controller to go idle");
		end
	endtask

	task automatic wait_seen(input int target);
		int n;
		n = 0;
		while (seen_total < target && n < XFER_TIMEOUT) begin
			next_cycle();
			n++;
		end
		if (seen_total < target) begin
			report_timeout("a transfer at the pins");
		end
	endtask

	// HD44780 instruction encodings for the init steps
	function automatic lcd_pkg::lcd_cmd_t init_cmd(input lcd_pkg::lcd_cfg_t c, input int step);
		lcd_pkg::lcd_cmd_t r;
		r.rs = 1'b0;
		case (step)
			0: r.data = {4'b0011, c.lines, c.font, 2'b00}; // 8-bit function set
			1: r.data = {5'b00001, c.disp_on, c.cursor_on, c.blink};
			2: r.data = 8'h01;
			default: r.data = {6'b000001, c.increment, c.shift};
		endcase
		return r;
	endfunction

	function automatic int slot_cycles(input lcd_pkg::lcd_cmd_t c);
		if (!c.rs && c.data[7:2] == 6'd0) begin
			return lcd_pkg::LONG_US * lcd_pkg::US_CYCLES; // clear or home
		end
		return lcd_pkg::SHORT_US * lcd_pkg::US_CYCLES;
	endfunction

	// pops n transfers and checks value, pulse shape and slot spacing
	task automatic check_transfers(input int n);
		xfer_t x;
		xfer_t prev;
		lcd_pkg::lcd_cmd_t exp;
		int k;
		for (k = 0; k < n; k++) begin
			wait_seen(seen_total - seen.size() + 1);
			if (seen.size() == 0) begin
				$display("Transfer %0d of %0d never appeared at the pins", k + 1, n);
				errors++;
				break;
			end
			x = seen.pop_front();
			exp = model.pop_front();
			compare_cmd("lcd transfer", exp, x.cmd);
			if (x.rw) begin
				$display("rw went high during a transfer at %0t ns", $time);
				errors++;
			end
			if (x.chg >= 0) begin
				compare_cycles("setup", lcd_pkg::SETUP_US * lcd_pkg::US_CYCLES, x.rise - x.chg);
			end
			compare_cycles("e high", lcd_pkg::E_HIGH_US * lcd_pkg::US_CYCLES, x.fall - x.rise);
			if (k > 0) begin
				compare_cycles("slot", slot_cycles(prev.cmd), x.rise - prev.rise);
			end
			prev = x;
		end
	endtask

	task automatic end_test(input string name, input int errs_before);
		if (errors == errs_before) begin
			$display("test %s: ok", name);
			tests_pass++;
		end else begin
			$display("test %s: %0d errors", name, errors - errs_before);
			tests_fail++;
		end
	endtask

	initial begin
		lcd_pkg::lcd_cfg_t cfg_w;
		lcd_pkg::lcd_cmd_t c;
		logic [31:0] r;
		logic [31:0] rdata;
		logic [1:0] resp;
		logic [1:0] exp_resp;
		int i;
		int errs0;
		int n0;
		int base;
		int okay;
		req = '0;
		void'($urandom(32'h9031));
		repeat (16) @(posedge clk);
		#0.5;
		rst = 1'b0;

		errs0 = errors;
		r = $urandom;
		cfg_w = r[6:0];
		axil_write(lcd_pkg::REG_CTRL, {23'd0, 1'b1, 1'b0, cfg_w}, resp); // start set
		compare_resp("bresp ctrl", lcd_pkg::RESP_OKAY, resp);
		for (i = 0; i < 4; i++) begin
			model.push_back(init_cmd(cfg_w, i));
		end
		check_transfers(4);
		if (first_rise >= 0 && first_rise < lcd_pkg::POWERUP_US * lcd_pkg::US_CYCLES) begin
			$display("Fail at %0t ns: first e rise expected after cycle %0d, got %0d",
				$time, lcd_pkg::POWERUP_US * lcd_pkg::US_CYCLES, first_rise);
			errors++;
		end
		end_test("initialisation", errs0);

		errs0 = errors;
		axil_read(lcd_pkg::REG_CTRL, rdata, resp);
		compare_resp("rresp ctrl", lcd_pkg::RESP_OKAY, resp);
		compare_word("ctrl rdata", {25'd0, cfg_w}, rdata);
		axil_read(lcd_pkg::REG_STATUS, rdata, resp);
		compare_word("status init_done", 32'h1, rdata & 32'h1);
		end_test("control readback", errs0);

		// keep the queue topped up so the slots run back to back
		errs0 = errors;
		n0 = seen_total;
		for (i = 0; i < 20; i++) begin
			if (i >= 6) begin
				wait_seen(n0 + i - 5);
			end
			r = $urandom;
			c = r[8:0];
			axil_write(lcd_pkg::REG_DATA, {23'd0, c}, resp);
			compare_resp("bresp data", lcd_pkg::RESP_OKAY, resp);
			if (resp == lcd_pkg::RESP_OKAY) begin
				model.push_back(c);
			end
			if (i == 5) begin
				axil_read(lcd_pkg::REG_STATUS, rdata, resp);
				compare_word("status busy", 32'h3, rdata & 32'h3);
				if (rdata[7:4] == 4'd0) begin
					$display("Fail at %0t ns: status count expected nonzero, got 0", $time);
					errors++;
				end
			end
		end
		check_transfers(20);
		end_test("data path and pulse timing", errs0);

		errs0 = errors;
		wait_idle(rdata);
		compare_word("status idle", 32'h1, rdata);
		end_test("status after drain", errs0);

		// occupancy follows from OKAY writes minus strobes already seen
		errs0 = errors;
		base = rise_total;
		okay = 0;
		for (i = 0; i < 12; i++) begin
			exp_resp = (okay - (rise_total - base) >= lcd_pkg::FIFO_DEPTH)
				? lcd_pkg::RESP_SLVERR : lcd_pkg::RESP_OKAY;
			r = $urandom;
			c = r[8:0];
			axil_write(lcd_pkg::REG_DATA, {23'd0, c}, resp);
			compare_resp("bresp burst", exp_resp, resp);
			if (resp == lcd_pkg::RESP_OKAY) begin
				okay++;
				model.push_back(c);
			end
		end
		check_transfers(okay);
		end_test("back-pressure", errs0);

		errs0 = errors;
		wait_idle(rdata);
		compare_word("status idle", 32'h1, rdata);
		axil_read(4'hC, rdata, resp);
		compare_resp("rresp unmapped", lcd_pkg::RESP_SLVERR, resp);
		compare_word("rdata unmapped", 32'h0, rdata);
		if (seen.size() != 0 || model.size() != 0) begin
			$display("%0d transfers at the pins were not expected, %0d expected ones missing",
				seen.size(), model.size());
			errors++;
		end
		end_test("registers", errs0);

		$display("tests passed %0d, failed %0d", tests_pass, tests_fail);
		if (errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

/* verilog.f */
hw/lcd_pkg.sv
hw/lcd_axil_regs.sv
hw/lcd_cmd_fifo.sv
hw/lcd_init_seq.sv
hw/lcd_bus_timing.sv
hw/lcd_top.sv
bench/lcd_tb.sv
